/* src/mbox_pkg.sv */
// ----------------------------------------
// mailbox shared definitions
// register indices, word and field types,
// fixed read-back values for both ports
// ----------------------------------------

package mbox_pkg;

  // ----------------------------------------
  // basic widths
  // ----------------------------------------
  typedef logic [31:0] data_t;     // one mailbox / register word
  typedef logic [3:0]  reg_addr_t; // word index inside a port window

  // register map of one port window, 10..15 unmapped
  typedef enum reg_addr_t {
    MBOXW  = 4'd0, // push into the outgoing FIFO
    MBOXR  = 4'd1, // pop from the incoming FIFO
    STATUS = 4'd2, // live FIFO flags and threshold compares
    ERROR  = 4'd3, // sticky mailbox errors, cleared on read
    WIRQT  = 4'd4, // write usage threshold
    RIRQT  = 4'd5, // read usage threshold
    IRQS   = 4'd6, // sticky irq status, write ones to clear
    IRQEN  = 4'd7, // irq enable mask
    IRQP   = 4'd8, // pending = status & enable
    CTRL   = 9     // flush pulses, reads back zero
  } reg_e;

  // ----------------------------------------
  // register field layouts
  // ----------------------------------------
  // [0] read FIFO empty, [1] write FIFO full
  // [2] write usage > WIRQT, [3] read usage > RIRQT
  typedef logic [3:0] status_t;

  // [0] read from empty mailbox, [1] write to full mailbox
  typedef logic [1:0] err_t;

  // [0] write threshold, [1] read threshold, [2] error
  typedef logic [2:0] irq_bits_t;

  // ----------------------------------------
  // fixed read-back words
  // ----------------------------------------
  localparam data_t MBOXW_READ_VALUE = 32'hFEED_C0DE; // MBOXW is write only
  localparam data_t EMPTY_READ_VALUE = 32'hFEED_DEAD; // MBOXR with nothing queued

endpackage

/* src/mbox_fifo.sv */
// ----------------------------------------
// mailbox FIFO, one direction
// registered storage, head word shown
// combinationally, usage count incl. full
// ----------------------------------------

module mbox_fifo #(
  parameter int unsigned MAILBOX_DEPTH = 4
) (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        push_i,   // from the writing port
  input  logic                        pop_i,    // from the reading port
  input  logic                        flush_i,  // either side may flush
  input  mbox_pkg::data_t             wdata_i,
  output mbox_pkg::data_t             rdata_o,  // head of queue
  output logic                        full_o,
  output logic                        empty_o,
  output logic [$clog2(MAILBOX_DEPTH):0] usage_o  // 0 .. MAILBOX_DEPTH
);

  localparam int unsigned PTR_W   = $clog2(MAILBOX_DEPTH);
  localparam int unsigned USAGE_W = PTR_W + 1; // extra msb so a full buffer is countable

  typedef logic [PTR_W-1:0]   ptr_t;
  typedef logic [USAGE_W-1:0] usage_t;

  mbox_pkg::data_t mem_q [MAILBOX_DEPTH]; // storage
  ptr_t            wr_ptr_q, rd_ptr_q;
  usage_t          count_q;
  logic            do_push, do_pop;

  // ----------------------------------------
  // flags and qualified strobes
  // ----------------------------------------
  assign full_o  = (count_q == usage_t'(MAILBOX_DEPTH));
  assign empty_o = (count_q == '0);
  assign usage_o = count_q;
  assign rdata_o = mem_q[rd_ptr_q]; // non fall-through, data only once stored

  assign do_push = push_i && (!full_o || pop_i); // a pop frees the slot this cycle
  assign do_pop  = pop_i && !empty_o;

  // storage write, wraps at any depth
  always_ff @(posedge clk_i) begin
    if (do_push && !flush_i) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

  // pointers and count
  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin      // flush beats any push or pop
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(MAILBOX_DEPTH - 1)) ? '0 : wr_ptr_q + ptr_t'(1);
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(MAILBOX_DEPTH - 1)) ? '0 : rd_ptr_q + ptr_t'(1);
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + usage_t'(1);
        2'b01:   count_q <= count_q - usage_t'(1);
        default: count_q <= count_q; // both or none, level unchanged
      endcase
    end
  end

  // ----------------------------------------
  // checks on the port side handshake
  // ----------------------------------------
  // the port must never push into a full mailbox unless the other port pops
  a_no_push_full : assert property (@(posedge clk_i) disable iff (reset_i)
    !(push_i && full_o && !pop_i));

  // the reading port only pops when data was reported available
  a_no_pop_empty : assert property (@(posedge clk_i) disable iff (reset_i)
    !(pop_i && empty_o));

endmodule

/* src/mbox_irq_ctrl.sv */
// ----------------------------------------
// mailbox interrupt control, one port
// usage thresholds, sticky irq status,
// enable mask and the level irq output
// ----------------------------------------

module mbox_irq_ctrl #(
  parameter int unsigned MAILBOX_DEPTH = 4
) (
  input  logic                           clk_i,
  input  logic                           reset_i,
  // decoded register writes from the port
  input  logic                           wirqt_we_i,
  input  logic                           rirqt_we_i,
  input  logic                           irqs_we_i,
  input  logic                           irqen_we_i,
  input  mbox_pkg::data_t                wdata_i,
  // FIFO levels
  input  logic [$clog2(MAILBOX_DEPTH):0] w_usage_i,
  input  logic [$clog2(MAILBOX_DEPTH):0] r_usage_i,
  input  logic                           err_event_i, // failed mailbox access
  // read-back values
  output mbox_pkg::data_t                wirqt_o,
  output mbox_pkg::data_t                rirqt_o,
  output mbox_pkg::irq_bits_t            irqs_o,
  output mbox_pkg::irq_bits_t            irqen_o,
  output mbox_pkg::irq_bits_t            irqp_o,
  output logic [1:0]                     thr_o,       // status bits 3:2
  output logic                           irq_o
);

  mbox_pkg::data_t     wirqt_q, rirqt_q;
  mbox_pkg::irq_bits_t irqs_q, irqen_q;
  mbox_pkg::irq_bits_t irqs_set, irqs_clr;

  // limit a threshold so the compare can still fire on a full FIFO
  function automatic mbox_pkg::data_t clamp_thr(input mbox_pkg::data_t val);
    if (val >= mbox_pkg::data_t'(MAILBOX_DEPTH)) begin
      return mbox_pkg::data_t'(MAILBOX_DEPTH - 1);
    end
    return val;
  endfunction

  // ----------------------------------------
  // threshold registers
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wirqt_q <= '0;
      rirqt_q <= '0;
    end else begin
      if (wirqt_we_i) wirqt_q <= clamp_thr(wdata_i);
      if (rirqt_we_i) rirqt_q <= clamp_thr(wdata_i);
    end
  end

  // strictly above, usage zero-extended to word width
  assign thr_o[0] = mbox_pkg::data_t'(w_usage_i) > wirqt_q; // write side
  assign thr_o[1] = mbox_pkg::data_t'(r_usage_i) > rirqt_q; // read side

  // ----------------------------------------
  // sticky status and enable
  // ----------------------------------------
  assign irqs_set = {err_event_i, thr_o};
  assign irqs_clr = irqs_we_i ? wdata_i[2:0] : '0; // write ones to clear

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      irqs_q  <= '0;
      irqen_q <= '0;
    end else begin
      irqs_q <= (irqs_q & ~irqs_clr) | irqs_set; // a live cause wins over the clear
      if (irqen_we_i) begin
        irqen_q <= wdata_i[2:0];
      end
    end
  end

  assign irqp_o  = irqs_q & irqen_q;
  assign irq_o   = |irqp_o; // level, active high
  assign irqs_o  = irqs_q;
  assign irqen_o = irqen_q;
  assign wirqt_o = wirqt_q;
  assign rirqt_o = rirqt_q;

endmodule

/* src/mbox_port.sv */
// ----------------------------------------
// mailbox host port
// register decode, error register, FIFO
// strobes and a one-cycle registered reply
// ----------------------------------------

module mbox_port #(
  parameter int unsigned MAILBOX_DEPTH = 4
) (
  input  logic                           clk_i,
  input  logic                           reset_i,
  // host request, single cycle strobe
  input  logic                           req_i,
  input  logic                           we_i,
  input  mbox_pkg::reg_addr_t            addr_i,
  input  mbox_pkg::data_t                wdata_i,
  // host reply, one cycle after the strobe
  output logic                           ack_o,
  output mbox_pkg::data_t                rdata_o,
  output logic                           err_o,
  output logic                           irq_o,
  // outgoing FIFO
  output logic                           w_push_o,
  output logic                           w_flush_o,
  output mbox_pkg::data_t                w_data_o,
  input  logic                           w_full_i,
  input  logic [$clog2(MAILBOX_DEPTH):0] w_usage_i,
  // incoming FIFO
  output logic                           r_pop_o,
  output logic                           r_flush_o,
  input  mbox_pkg::data_t                r_data_i,
  input  logic                           r_empty_i,
  input  logic [$clog2(MAILBOX_DEPTH):0] r_usage_i
);

  mbox_pkg::reg_e      reg_sel;
  mbox_pkg::status_t   status;
  mbox_pkg::err_t      error_q, err_set;
  logic                err_clr;
  mbox_pkg::data_t     rdata_d, rdata_q;
  logic                err_d, err_q, ack_q;
  logic                wirqt_we, rirqt_we, irqs_we, irqen_we;
  mbox_pkg::data_t     wirqt, rirqt;
  mbox_pkg::irq_bits_t irqs, irqen, irqp;
  logic [1:0]          thr;

  assign reg_sel  = mbox_pkg::reg_e'(addr_i);
  assign w_data_o = wdata_i;                       // full word, no strobes
  assign status   = {thr, w_full_i, r_empty_i};    // live, not registered

  // ----------------------------------------
  // request decode
  // ----------------------------------------
  always_comb begin
    rdata_d   = '0;    // writes and unmapped reads answer zero
    err_d     = 1'b0;
    err_set   = '0;
    err_clr   = 1'b0;
    w_push_o  = 1'b0;
    w_flush_o = 1'b0;
    r_pop_o   = 1'b0;
    r_flush_o = 1'b0;
    wirqt_we  = 1'b0;
    rirqt_we  = 1'b0;
    irqs_we   = 1'b0;
    irqen_we  = 1'b0;
    if (req_i && we_i) begin
      case (reg_sel)
        mbox_pkg::MBOXW: begin
          if (!w_full_i) begin
            w_push_o = 1'b1;
          end else begin           // mailbox full, word dropped
            err_d      = 1'b1;
            err_set[1] = 1'b1;
          end
        end
        mbox_pkg::WIRQT: wirqt_we = 1'b1;
        mbox_pkg::RIRQT: rirqt_we = 1'b1;
        mbox_pkg::IRQS:  irqs_we  = 1'b1;
        mbox_pkg::IRQEN: irqen_we = 1'b1;
        mbox_pkg::CTRL: begin
          w_flush_o = wdata_i[0];  // flush outgoing
          r_flush_o = wdata_i[1];  // flush incoming
        end
        default: err_d = 1'b1;     // read-only or unmapped
      endcase
    end else if (req_i) begin
      case (reg_sel)
        mbox_pkg::MBOXW: rdata_d = mbox_pkg::MBOXW_READ_VALUE;
        mbox_pkg::MBOXR: begin
          if (!r_empty_i) begin
            rdata_d = r_data_i;
            r_pop_o = 1'b1;
          end else begin
            rdata_d    = mbox_pkg::EMPTY_READ_VALUE;
            err_d      = 1'b1;
            err_set[0] = 1'b1;
          end
        end
        mbox_pkg::STATUS: rdata_d = mbox_pkg::data_t'(status);
        mbox_pkg::ERROR: begin
          rdata_d = mbox_pkg::data_t'(error_q);
          err_clr = 1'b1;          // read clears
        end
        mbox_pkg::WIRQT: rdata_d = wirqt;
        mbox_pkg::RIRQT: rdata_d = rirqt;
        mbox_pkg::IRQS:  rdata_d = mbox_pkg::data_t'(irqs);
        mbox_pkg::IRQEN: rdata_d = mbox_pkg::data_t'(irqen);
        mbox_pkg::IRQP:  rdata_d = mbox_pkg::data_t'(irqp);
        mbox_pkg::CTRL:  rdata_d = '0; // flush bits are pulses
        default:         err_d   = 1'b1;
      endcase
    end
  end

  // ----------------------------------------
  // error register and reply
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      error_q <= '0;
      err_q   <= 1'b0;
      ack_q   <= 1'b0;
    end else begin
      error_q <= (err_clr ? '0 : error_q) | err_set; // new failure survives the clear
      err_q   <= err_d;
      ack_q   <= req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    rdata_q <= rdata_d; // reply word for the ack cycle
  end

  assign ack_o   = ack_q;
  assign err_o   = err_q;
  assign rdata_o = rdata_q;

  mbox_irq_ctrl #(
    .MAILBOX_DEPTH ( MAILBOX_DEPTH )
  ) irq_ctrl (
    .clk_i       ( clk_i      ),
    .reset_i     ( reset_i    ),
    .wirqt_we_i  ( wirqt_we   ),
    .rirqt_we_i  ( rirqt_we   ),
    .irqs_we_i   ( irqs_we    ),
    .irqen_we_i  ( irqen_we   ),
    .wdata_i     ( wdata_i    ),
    .w_usage_i   ( w_usage_i  ),
    .r_usage_i   ( r_usage_i  ),
    .err_event_i ( |err_set   ), // only failed mailbox accesses raise the irq
    .wirqt_o     ( wirqt      ),
    .rirqt_o     ( rirqt      ),
    .irqs_o      ( irqs       ),
    .irqen_o     ( irqen      ),
    .irqp_o      ( irqp       ),
    .thr_o       ( thr        ),
    .irq_o       ( irq_o      )
  );

  // flags and levels of both FIFOs must agree, so the crossing at the top is sound
  a_fifo_flags_agree : assert property (@(posedge clk_i) disable iff (reset_i)
    (r_empty_i == (r_usage_i == '0)) && (w_full_i == (w_usage_i == MAILBOX_DEPTH)));

endmodule

/* src/mbox_top.sv */
// ----------------------------------------
// two-port mailbox top
// two host ports, two FIFOs crossed
// between them, one irq per port
// ----------------------------------------

module mbox_top #(
  parameter int unsigned MAILBOX_DEPTH = 4
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                [1:0] req_i,   // index is the port
  input  logic                [1:0] we_i,
  input  mbox_pkg::reg_addr_t [1:0] addr_i,
  input  mbox_pkg::data_t     [1:0] wdata_i,
  output logic                [1:0] ack_o,
  output mbox_pkg::data_t     [1:0] rdata_o,
  output logic                [1:0] err_o,
  output logic                [1:0] irq_o    // level, active high
);

  localparam int unsigned USAGE_W = $clog2(MAILBOX_DEPTH) + 1;

  // index is the port
  logic            [1:0] w_push, w_flush, r_pop, r_flush;
  mbox_pkg::data_t [1:0] w_data;
  // index is the FIFO, 0 = port 0 to port 1, 1 = port 1 to port 0
  logic               [1:0] fifo_full, fifo_empty;
  mbox_pkg::data_t    [1:0] fifo_rdata;
  logic [USAGE_W-1:0]       fifo_usage [2];

  // ----------------------------------------
  // host ports, each writes its own FIFO
  // and reads the other one
  // ----------------------------------------
  mbox_port #(
    .MAILBOX_DEPTH ( MAILBOX_DEPTH )
  ) port_0 (
    .clk_i     ( clk_i         ),
    .reset_i   ( reset_i       ),
    .req_i     ( req_i[0]      ),
    .we_i      ( we_i[0]       ),
    .addr_i    ( addr_i[0]     ),
    .wdata_i   ( wdata_i[0]    ),
    .ack_o     ( ack_o[0]      ),
    .rdata_o   ( rdata_o[0]    ),
    .err_o     ( err_o[0]      ),
    .irq_o     ( irq_o[0]      ),
    .w_push_o  ( w_push[0]     ),
    .w_flush_o ( w_flush[0]    ),
    .w_data_o  ( w_data[0]     ),
    .w_full_i  ( fifo_full[0]  ),
    .w_usage_i ( fifo_usage[0] ),
    .r_pop_o   ( r_pop[0]      ),
    .r_flush_o ( r_flush[0]    ),
    .r_data_i  ( fifo_rdata[1] ),
    .r_empty_i ( fifo_empty[1] ),
    .r_usage_i ( fifo_usage[1] )
  );

  mbox_port #(
    .MAILBOX_DEPTH ( MAILBOX_DEPTH )
  ) port_1 (
    .clk_i     ( clk_i         ),
    .reset_i   ( reset_i       ),
    .req_i     ( req_i[1]      ),
    .we_i      ( we_i[1]       ),
    .addr_i    ( addr_i[1]     ),
    .wdata_i   ( wdata_i[1]    ),
    .ack_o     ( ack_o[1]      ),
    .rdata_o   ( rdata_o[1]    ),
    .err_o     ( err_o[1]      ),
    .irq_o     ( irq_o[1]      ),
    .w_push_o  ( w_push[1]     ),
    .w_flush_o ( w_flush[1]    ),
    .w_data_o  ( w_data[1]     ),
    .w_full_i  ( fifo_full[1]  ),
    .w_usage_i ( fifo_usage[1] ),
    .r_pop_o   ( r_pop[1]      ),
    .r_flush_o ( r_flush[1]    ),
    .r_data_i  ( fifo_rdata[0] ),
    .r_empty_i ( fifo_empty[0] ),
    .r_usage_i ( fifo_usage[0] )
  );

  // ----------------------------------------
  // mailbox FIFOs, flushed from either end
  // ----------------------------------------
  mbox_fifo #(
    .MAILBOX_DEPTH ( MAILBOX_DEPTH )
  ) fifo_0to1 (
    .clk_i   ( clk_i                     ),
    .reset_i ( reset_i                   ),
    .push_i  ( w_push[0]                 ),
    .pop_i   ( r_pop[1]                  ),
    .flush_i ( w_flush[0] | r_flush[1]   ), // writer or reader side
    .wdata_i ( w_data[0]                 ),
    .rdata_o ( fifo_rdata[0]             ),
    .full_o  ( fifo_full[0]              ),
    .empty_o ( fifo_empty[0]             ),
    .usage_o ( fifo_usage[0]             )
  );

  mbox_fifo #(
    .MAILBOX_DEPTH ( MAILBOX_DEPTH )
  ) fifo_1to0 (
    .clk_i   ( clk_i                     ),
    .reset_i ( reset_i                   ),
    .push_i  ( w_push[1]                 ),
    .pop_i   ( r_pop[0]                  ),
    .flush_i ( w_flush[1] | r_flush[0]   ),
    .wdata_i ( w_data[1]                 ),
    .rdata_o ( fifo_rdata[1]             ),
    .full_o  ( fifo_full[1]              ),
    .empty_o ( fifo_empty[1]             ),
    .usage_o ( fifo_usage[1]             )
  );

endmodule

/* bench/mbox_tb_table.svh */
// ----------------------------------------
// mailbox testbench access table
// columns: port, we, addr, wdata,
// expected rdata, err, irq_o[1:0]
// ----------------------------------------

task automatic load_table();
  // data transfer, port 0 to port 1 and back
  add_row(0, 1'b1, mbox_pkg::MBOXW,  32'h1111_1111, 32'h0000_0000, 1'b0, 2'b00);
  add_row(0, 1'b1, mbox_pkg::MBOXW,  32'h2222_2222, 32'h0000_0000, 1'b0, 2'b00);
  add_row(0, 1'b1, mbox_pkg::MBOXW,  32'h3333_3333, 32'h0000_0000, 1'b0, 2'b00);
  add_row(1, 1'b0, mbox_pkg::MBOXR,  32'h0000_0000, 32'h1111_1111, 1'b0, 2'b00);
  add_row(1, 1'b0, mbox_pkg::MBOXR,  32'h0000_0000, 32'h2222_2222, 1'b0, 2'b00);
  add_row(1, 1'b0, mbox_pkg::MBOXR,  32'h0000_0000, 32'h3333_3333, 1'b0, 2'b00);
  add_row(1, 1'b1, mbox_pkg::MBOXW,  32'hA5A5_A5A5, 32'h0000_0000, 1'b0, 2'b00);
  add_row(1, 1'b1, mbox_pkg::MBOXW,  32'h5A5A_5A5A, 32'h0000_0000, 1'b0, 2'b00);
  add_row(0, 1'b0, mbox_pkg::MBOXR,  32'h0000_0000, 32'hA5A5_A5A5, 1'b0, 2'b00);
  add_row(0, 1'b0, mbox_pkg::MBOXR,  32'h0000_0000, 32'h5A5A_5A5A, 1'b0, 2'b00);
  // empty read, error clear on read, write-only MBOXW
  add_row(1, 1'b0, mbox_pkg::MBOXR,  32'h0000_0000, 32'hFEED_DEAD, 1'b1, 2'b00);
  add_row(1, 1'b0, mbox_pkg::ERROR,  32'h0000_0000, 32'h0000_0001, 1'b0, 2'b00);
  add_row(1, 1'b0, mbox_pkg::ERROR,  32'h0000_0000, 32'h0000_0000, 1'b0, 2'b00);
  add_row(0, 1'b0, mbox_pkg::MBOXW,  32'h0000_0000, 32'hFEED_C0DE, 1'b0, 2'b00);
  // fill the 0 to 1 mailbox, overflow, reader side flush
  add_row(0, 1'b1, mbox_pkg::MBOXW,  32'h0000_0001, 32'h0000_0000, 1'b0, 2'b00);
  add_row(0, 1'b1, mbox_pkg::MBOXW,  32'h0000_0002, 32'h0000_0000, 1'b0, 2'b00);
  add_row(0, 1'b1, mbox_pkg::MBOXW,  32'h0000_0003, 32'h0000_0000, 1'b0, 2'b00);
  add_row(0, 1'b1, mbox_pkg::MBOXW,  32'h0000_0004, 32'h0000_0000, 1'b0, 2'b00);
  add_row(0, 1'b0, mbox_pkg::STATUS, 32'h0000_0000, 32'h0000_0007, 1'b0, 2'b00);
  add_row(0, 1'b1, mbox_pkg::MBOXW,  32'h0000_0005, 32'h0000_0000, 1'b1, 2'b00);
  add_row(0, 1'b0, mbox_pkg::ERROR,  32'h0000_0000, 32'h0000_0002, 1'b0, 2'b00);
  add_row(1, 1'b1, mbox_pkg::CTRL,   32'h0000_0002, 32'h0000_0000, 1'b0, 2'b00);
  // write threshold clamp and irq on port 0
  add_row(0, 1'b1, mbox_pkg::WIRQT,  32'h0000_0009, 32'h0000_0000, 1'b0, 2'b00);
  add_row(0, 1'b0, mbox_pkg::WIRQT,  32'h0000_0000, 32'h0000_0003, 1'b0, 2'b00);
  add_row(0, 1'b1, mbox_pkg::WIRQT,  32'h0000_0001, 32'h0000_0000, 1'b0, 2'b00);
  add_row(0, 1'b1, mbox_pkg::IRQS,   32'h0000_0007, 32'h0000_0000, 1'b0, 2'b00);
  add_row(0, 1'b1, mbox_pkg::IRQEN,  32'h0000_0001, 32'h0000_0000, 1'b0, 2'b00);
  add_row(0, 1'b1, mbox_pkg::MBOXW,  32'hC0C0_0001, 32'h0000_0000, 1'b0, 2'b00);
  add_row(0, 1'b1, mbox_pkg::MBOXW,  32'hC0C0_0002, 32'h0000_0000, 1'b0, 2'b01);
  add_row(0, 1'b1, mbox_pkg::IRQS,   32'h0000_0001, 32'h0000_0000, 1'b0, 2'b01);
  add_row(1, 1'b0, mbox_pkg::MBOXR,  32'h0000_0000, 32'hC0C0_0001, 1'b0, 2'b01);
  add_row(1, 1'b0, mbox_pkg::MBOXR,  32'h0000_0000, 32'hC0C0_0002, 1'b0, 2'b01);
  add_row(0, 1'b1, mbox_pkg::IRQS,   32'h0000_0001, 32'h0000_0000, 1'b0, 2'b00);
  // writer side flush of the 1 to 0 mailbox
  add_row(1, 1'b1, mbox_pkg::MBOXW,  32'hD0D0_0001, 32'h0000_0000, 1'b0, 2'b00);
  add_row(1, 1'b1, mbox_pkg::MBOXW,  32'hD0D0_0002, 32'h0000_0000, 1'b0, 2'b00);
  add_row(1, 1'b1, mbox_pkg::CTRL,   32'h0000_0001, 32'h0000_0000, 1'b0, 2'b00);
  add_row(0, 1'b0, mbox_pkg::STATUS, 32'h0000_0000, 32'h0000_0001, 1'b0, 2'b00);
  add_row(0, 1'b0, mbox_pkg::MBOXR,  32'h0000_0000, 32'hFEED_DEAD, 1'b1, 2'b00);
  // illegal accesses leave the queued word alone
  add_row(1, 1'b1, mbox_pkg::MBOXW,  32'hE0E0_0001, 32'h0000_0000, 1'b0, 2'b00);
  add_row(1, 1'b0, 4'd12,            32'h0000_0000, 32'h0000_0000, 1'b1, 2'b00);
  add_row(1, 1'b1, mbox_pkg::STATUS, 32'hFFFF_FFFF, 32'h0000_0000, 1'b1, 2'b00);
  add_row(1, 1'b0, mbox_pkg::STATUS, 32'h0000_0000, 32'h0000_0005, 1'b0, 2'b00);
  add_row(1, 1'b0, mbox_pkg::ERROR,  32'h0000_0000, 32'h0000_0000, 1'b0, 2'b00);
  add_row(0, 1'b0, mbox_pkg::MBOXR,  32'h0000_0000, 32'hE0E0_0001, 1'b0, 2'b00);
endtask

/* bench/mbox_tb.sv */
// ----------------------------------------
// two-port mailbox testbench
// walks a table of host accesses and
// checks reply data, err flag and irqs
// ----------------------------------------

module mbox_tb;

  logic                      clk;
  logic                      reset;
  logic                [1:0] req;    // index is the port
  logic                [1:0] we;
  mbox_pkg::reg_addr_t [1:0] addr;
  mbox_pkg::data_t     [1:0] wdata;
  logic                [1:0] ack;
  mbox_pkg::data_t     [1:0] rdata;
  logic                [1:0] err;
  logic                [1:0] irq;

  // table columns, one entry per row
  int                  row_port  [$];
  logic                row_we    [$];
  mbox_pkg::reg_addr_t row_addr  [$];
  mbox_pkg::data_t     row_wdata [$];
  mbox_pkg::data_t     row_rdata [$];
  logic                row_err   [$];
  logic [1:0]          row_irq   [$];
  logic                table_ready = 1'b0;

  mbox_top #(
    .MAILBOX_DEPTH ( 4 )
  ) uut (
    .clk_i   ( clk   ),
    .reset_i ( reset ),
    .req_i   ( req   ),
    .we_i    ( we    ),
    .addr_i  ( addr  ),
    .wdata_i ( wdata ),
    .ack_o   ( ack   ),
    .rdata_o ( rdata ),
    .err_o   ( err   ),
    .irq_o   ( irq   )
  );

  // ----------------------------------------
  // reporting and compare tasks
  // ----------------------------------------
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input mbox_pkg::data_t exp,
                            input mbox_pkg::data_t act);
    if (act !== exp) begin
      abort_run($sformatf("ERROR t=%0t %s expected %h got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("ERROR t=%0t %s expected %b got %b", $time, name, exp, act));
    end
  endtask

  task automatic check_irq(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp) begin
      abort_run($sformatf("ERROR t=%0t %s expected %b got %b", $time, name, exp, act));
    end
  endtask

  // one table row, appended in order
  task automatic add_row(input int port, input logic w, input mbox_pkg::reg_addr_t a,
                         input mbox_pkg::data_t wd, input mbox_pkg::data_t exp_rd,
                         input logic exp_e, input logic [1:0] exp_irq);
    row_port.push_back(port);
    row_we.push_back(w);
    row_addr.push_back(a);
    row_wdata.push_back(wd);
    row_rdata.push_back(exp_rd);
    row_err.push_back(exp_e);
    row_irq.push_back(exp_irq);
  endtask

  `include "mbox_tb_table.svh"

  // strobe, reply check, irq check one cycle later, then the idle cycle
  task automatic run_row(input int i);
    int p;
    p = row_port[i];
    @(negedge clk);
    req[p]   = 1'b1;
    we[p]    = row_we[i];
    addr[p]  = row_addr[i];
    wdata[p] = row_wdata[i];
    @(negedge clk);                     // ack cycle
    req[p]   = 1'b0;
    we[p]    = 1'b0;
    addr[p]  = '0;
    wdata[p] = '0;
    if (ack !== (2'b01 << p)) begin
      abort_run($sformatf("row %0d: port %0d did not acknowledge its request (ack %b)",
                          i, p, ack));
    end
    check_data($sformatf("rdata_o[%0d]", p), row_rdata[i], rdata[p]);
    check_err($sformatf("err_o[%0d]", p), row_err[i], err[p]);
    @(negedge clk);                     // irq status registered by now
    check_irq("irq_o", row_irq[i], irq);
  endtask

  // ----------------------------------------
  // clock, watchdog, main sequence
  // ----------------------------------------
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // three cycles per row plus reset margin
  initial begin
    wait (table_ready);
    #((row_port.size() * 3 + 10) * 4);
    abort_run("watchdog expired before the last table row was done");
  end

  initial begin
    req   = '0;
    we    = '0;
    addr  = '0;
    wdata = '0;
    reset = 1'b1;
    load_table();
    table_ready = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    foreach (row_port[i]) begin
      run_row(i);
    end
    $display("sim passed");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+bench
src/mbox_pkg.sv
src/mbox_fifo.sv
src/mbox_irq_ctrl.sv
src/mbox_port.sv
src/mbox_top.sv
bench/mbox_tb.sv
